// File: rtl/game_pkg.sv
// Game types shared by the decoder, control FSM, datapath, ROM and top level
package game_pkg;

    // Depth of the fixed sequence table
    localparam int SEQ_DEPTH = 16;

    typedef logic [3:0] button_t;
    typedef logic [3:0] addr_t;

    // One press event, strobe high for a single cycle
    typedef struct packed {
        logic    strobe;
        button_t code;
    } play_t;

    typedef struct packed {
        logic acertou;
        logic errou;
        logic pronto;
        logic timed_out;
    } game_status_t;

    // ------------------------------------------------------------------
    // Control to datapath commands and the flags coming back
    // ------------------------------------------------------------------
    typedef struct packed {
        logic clear_addr;
        logic step_addr;
        logic clear_limit;
        logic step_limit;
        logic run_timer;
    } ctrl_cmd_t;

    typedef struct packed {
        logic addr_at_limit;
        logic limit_at_last;
        logic match;
        logic timer_done;
    } dp_flags_t;

    // Codes picked to read well on the state display
    typedef enum logic [3:0] {
        idle       = 4'h0,
        start      = 4'h1,
        wait_play  = 4'h2,
        compare    = 4'h3,
        next_play  = 4'h4,
        next_round = 4'h5,
        won        = 4'hA,
        lost       = 4'hE
    } game_state_t;

endpackage

// File: rtl/display_pkg.sv
// Seven-segment types for the debug displays, used by the encoder and top level
package display_pkg;

    // Segments gfedcba, active low
    typedef logic [6:0] seg7_t;

    typedef logic [3:0] nibble_t;

    // ------------------------------------------------------------------
    // Five debug digits, play digit in the upper bits
    // ------------------------------------------------------------------
    typedef struct packed {
        seg7_t play;
        seg7_t address;
        seg7_t memory;
        seg7_t state;
        seg7_t limit;
    } debug_disp_t;

endpackage

// File: rtl/play_decoder.sv
// Samples the button lines and turns each fresh press into a one-cycle play event
`timescale 1ns/1ps

module play_decoder (
    input  logic              clock,
    input  logic              reset,
    input  game_pkg::button_t botoes,
    output game_pkg::play_t   play,
    output game_pkg::button_t leds
);
    import game_pkg::*;

    button_t botoes_q;
    button_t botoes_prev;
    logic    press;

    // New press when some line is up and all were down the cycle before
    assign press = (botoes_q != '0) && (botoes_prev == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            botoes_q    <= '0;
            botoes_prev <= '0;
            play        <= '0;
        end else begin
            botoes_q    <= botoes;
            botoes_prev <= botoes_q;
            play.strobe <= press;
            // Code holds until the next press so compare can still see it
            if (press) begin
                play.code <= botoes_q;
            end
        end
    end

    // Echo of the sampled buttons
    assign leds = botoes_q;

    // A held button never produces a second strobe
    a_single_strobe: assert property (
        @(posedge clock) disable iff (reset)
        play.strobe |=> !play.strobe
    ) else $error("play strobe high on two consecutive cycles");

endmodule

// File: rtl/sequence_rom.sv
// Fixed table of one-hot button codes that the player has to repeat
`timescale 1ns/1ps

module sequence_rom (
    input  game_pkg::addr_t   addr,
    output game_pkg::button_t word
);
    import game_pkg::*;

    localparam button_t BTN0 = 4'b0001;
    localparam button_t BTN1 = 4'b0010;
    localparam button_t BTN2 = 4'b0100;
    localparam button_t BTN3 = 4'b1000;

    // Pattern of eight entries, stored twice
    always_comb begin
        case (addr)
            4'd0:  word = BTN0;
            4'd1:  word = BTN1;
            4'd2:  word = BTN2;
            4'd3:  word = BTN3;
            4'd4:  word = BTN1;
            4'd5:  word = BTN3;
            4'd6:  word = BTN0;
            4'd7:  word = BTN2;
            4'd8:  word = BTN0;
            4'd9:  word = BTN1;
            4'd10: word = BTN2;
            4'd11: word = BTN3;
            4'd12: word = BTN1;
            4'd13: word = BTN3;
            4'd14: word = BTN0;
            4'd15: word = BTN2;
            default: word = BTN0;
        endcase
    end

    always_comb begin
        if (!$isunknown(addr)) begin
            a_word_onehot: assert ($onehot(word))
                else $error("ROM word %h at address %0d is not one-hot", word, addr);
        end
    end

endmodule

// File: rtl/game_datapath.sv
// Address, limit and timeout counters with the compares that feed the game FSM
`timescale 1ns/1ps

module game_datapath #(
    parameter int SEQ_LEN        = 16,
    parameter int TIMEOUT_CYCLES = 5000
) (
    input  logic                clock,
    input  logic                reset,
    input  game_pkg::ctrl_cmd_t cmd,
    input  game_pkg::play_t     play,
    input  game_pkg::button_t   rom_word,
    output game_pkg::addr_t     addr,
    output game_pkg::addr_t     limit,
    output game_pkg::dp_flags_t flags
);
    import game_pkg::*;

    localparam int                 TIMER_W   = $clog2(TIMEOUT_CYCLES + 1);
    localparam addr_t              LAST_ADDR = addr_t'(SEQ_LEN - 1);
    localparam logic [TIMER_W-1:0] TIMER_END = TIMER_W'(TIMEOUT_CYCLES - 1);

    logic [TIMER_W-1:0] timer;

    initial begin
        assert (SEQ_LEN >= 1 && SEQ_LEN <= SEQ_DEPTH && TIMEOUT_CYCLES >= 1)
            else $fatal(1, "SEQ_LEN %0d or TIMEOUT_CYCLES %0d out of range",
                        SEQ_LEN, TIMEOUT_CYCLES);
    end

    // ------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------
    // Position inside the current round
    always_ff @(posedge clock) begin
        if (reset) begin
            addr <= '0;
        end else if (cmd.clear_addr) begin
            addr <= '0;
        end else if (cmd.step_addr) begin
            addr <= addr + addr_t'(1);
        end
    end

    // Last position required in this round
    always_ff @(posedge clock) begin
        if (reset) begin
            limit <= '0;
        end else if (cmd.clear_limit) begin
            limit <= '0;
        end else if (cmd.step_limit) begin
            limit <= limit + addr_t'(1);
        end
    end

    // Runs only while waiting for a press, saturates at the end
    always_ff @(posedge clock) begin
        if (reset) begin
            timer <= '0;
        end else if (!cmd.run_timer || play.strobe) begin
            timer <= '0;
        end else if (!flags.timer_done) begin
            timer <= timer + TIMER_W'(1);
        end
    end

    // ------------------------------------------------------------------
    // Compares
    // ------------------------------------------------------------------
    assign flags.addr_at_limit = (addr == limit);
    assign flags.limit_at_last = (limit == LAST_ADDR);
    assign flags.match         = (play.code == rom_word);
    assign flags.timer_done    = (timer == TIMER_END);

    // The FSM must stop growing the round at the last entry
    a_limit_in_range: assert property (
        @(posedge clock) disable iff (reset)
        limit <= LAST_ADDR
    ) else $error("limit %0d beyond last entry %0d", limit, LAST_ADDR);

endmodule

// File: rtl/game_control.sv
// Game FSM that runs the rounds, drives the datapath and holds the result flags
`timescale 1ns/1ps

module game_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   jogar,
    input  game_pkg::play_t        play,
    input  game_pkg::dp_flags_t    flags,
    output game_pkg::ctrl_cmd_t    cmd,
    output game_pkg::game_status_t status,
    output game_pkg::game_state_t  state
);
    import game_pkg::*;

    game_state_t  state_next;
    game_status_t status_next;

    // ------------------------------------------------------------------
    // Next state and result flags
    // ------------------------------------------------------------------
    always_comb begin
        state_next  = state;
        status_next = status;
        case (state)
            idle, won, lost: begin
                // New game wipes the previous result
                if (jogar) begin
                    state_next  = start;
                    status_next = '0;
                end
            end
            start: begin
                state_next = wait_play;
            end
            wait_play: begin
                if (play.strobe) begin
                    state_next = compare;
                end else if (flags.timer_done) begin
                    state_next            = lost;
                    status_next.errou     = 1'b1;
                    status_next.pronto    = 1'b1;
                    status_next.timed_out = 1'b1;
                end
            end
            compare: begin
                if (!flags.match) begin
                    state_next         = lost;
                    status_next.errou  = 1'b1;
                    status_next.pronto = 1'b1;
                end else if (flags.addr_at_limit && flags.limit_at_last) begin
                    state_next          = won;
                    status_next.acertou = 1'b1;
                    status_next.pronto  = 1'b1;
                end else if (flags.addr_at_limit) begin
                    state_next = next_round;
                end else begin
                    state_next = next_play;
                end
            end
            next_play, next_round: begin
                state_next = wait_play;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= idle;
            status <= '0;
        end else begin
            state  <= state_next;
            status <= status_next;
        end
    end

    // ------------------------------------------------------------------
    // Datapath commands, decoded from the state alone
    // ------------------------------------------------------------------
    always_comb begin
        cmd = '0;
        case (state)
            start: begin
                cmd.clear_addr  = 1'b1;
                cmd.clear_limit = 1'b1;
            end
            wait_play: begin
                cmd.run_timer = 1'b1;
            end
            next_play: begin
                cmd.step_addr = 1'b1;
            end
            next_round: begin
                cmd.clear_addr = 1'b1;
                cmd.step_limit = 1'b1;
            end
            default: begin
                cmd = '0;
            end
        endcase
    end

    a_one_result: assert property (
        @(posedge clock) disable iff (reset)
        !(status.acertou && status.errou)
    ) else $error("acertou and errou raised together");

endmodule

// File: rtl/status_display.sv
// Turns the five debug values into seven-segment codes for the board displays
`timescale 1ns/1ps

module status_display (
    input  game_pkg::button_t        play_code,
    input  game_pkg::addr_t          addr,
    input  game_pkg::button_t        mem_word,
    input  game_pkg::game_state_t    state,
    input  game_pkg::addr_t          limit,
    output display_pkg::debug_disp_t debug
);
    import display_pkg::*;

    // Hex digit to segments gfedcba, low lights a segment
    function automatic seg7_t hex_to_seg(input nibble_t value);
        seg7_t seg;
        case (value)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    assign debug.play    = hex_to_seg(nibble_t'(play_code));
    assign debug.address = hex_to_seg(nibble_t'(addr));
    assign debug.memory  = hex_to_seg(nibble_t'(mem_word));
    assign debug.state   = hex_to_seg(nibble_t'(state));
    assign debug.limit   = hex_to_seg(nibble_t'(limit));

endmodule

// File: rtl/memory_game.sv
// Top level of the sequence memory game, wiring decoder, FSM, datapath, ROM and displays
`timescale 1ns/1ps

module memory_game #(
    parameter int SEQ_LEN        = 16,
    parameter int TIMEOUT_CYCLES = 5000
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     jogar,
    input  game_pkg::button_t        botoes,
    output game_pkg::game_status_t   status,
    output game_pkg::button_t        leds,
    output display_pkg::debug_disp_t debug,
    output game_pkg::game_state_t    db_state
);
    import game_pkg::*;

    play_t     play;
    ctrl_cmd_t cmd;
    dp_flags_t flags;
    addr_t     addr;
    addr_t     limit;
    button_t   rom_word;

    play_decoder i_decoder (
        .clock  ( clock  ),
        .reset  ( reset  ),
        .botoes ( botoes ),
        .play   ( play   ),
        .leds   ( leds   )
    );

    game_control i_control (
        .clock  ( clock    ),
        .reset  ( reset    ),
        .jogar  ( jogar    ),
        .play   ( play     ),
        .flags  ( flags    ),
        .cmd    ( cmd      ),
        .status ( status   ),
        .state  ( db_state )
    );

    game_datapath #(
        .SEQ_LEN        ( SEQ_LEN        ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) i_datapath (
        .clock    ( clock    ),
        .reset    ( reset    ),
        .cmd      ( cmd      ),
        .play     ( play     ),
        .rom_word ( rom_word ),
        .addr     ( addr     ),
        .limit    ( limit    ),
        .flags    ( flags    )
    );

    sequence_rom i_rom (
        .addr ( addr     ),
        .word ( rom_word )
    );

    // Debug digits: play, address, memory word, state and limit
    status_display i_display (
        .play_code ( play.code ),
        .addr      ( addr      ),
        .mem_word  ( rom_word  ),
        .state     ( db_state  ),
        .limit     ( limit     ),
        .debug     ( debug     )
    );

endmodule

// File: testbench/tb_game_tasks.svh
// Compare tasks and button and result helpers, included inside the memory game testbench

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_status(input game_status_t expected);
    if (status !== expected) begin
        stop_on_error($sformatf("ERR status expected 0x%h got 0x%h", expected, status));
    end
endtask

task automatic check_leds(input button_t expected);
    if (leds !== expected) begin
        stop_on_error($sformatf("ERR leds expected 0x%h got 0x%h", expected, leds));
    end
endtask

task automatic check_state(input game_state_t expected);
    if (db_state !== expected) begin
        stop_on_error($sformatf("ERR db_state expected 0x%h got 0x%h", expected, db_state));
    end
endtask

task automatic check_debug(input debug_disp_t expected);
    if (debug !== expected) begin
        stop_on_error($sformatf("ERR debug expected 0x%h got 0x%h", expected, debug));
    end
endtask

// ----------------------------------------------------------------------
// Helpers, all called and returning on a falling edge
// ----------------------------------------------------------------------
// Hold the code for hold cycles, then release for gap cycles
task automatic press_button(input button_t code, input int hold, input int gap);
    botoes = code;
    @(negedge clock);
    // Echo shows up one cycle after the drive
    check_leds(code);
    repeat (hold - 1) @(negedge clock);
    botoes = '0;
    repeat (gap) @(negedge clock);
endtask

// Counts falling edges until pronto is seen
task automatic wait_pronto(input int max_cycles, output int cycles);
    cycles = 0;
    while (!status.pronto && cycles < max_cycles) begin
        @(negedge clock);
        cycles++;
    end
    if (!status.pronto) begin
        stop_on_error($sformatf("Game gave no result within %0d cycles", max_cycles));
    end
endtask

// File: testbench/tb_memory_game.sv
// Self-checking testbench for the memory game, plays a table of scripted games
`timescale 1ns/1ps

module tb_memory_game;
    import game_pkg::*;
    import display_pkg::*;

    localparam int SEQ_LEN         = 4;
    localparam int TIMEOUT_CYCLES  = 50;
    localparam int CLOCK_PERIOD    = 40;
    localparam int RESULT_LATENCY  = 3;
    localparam int NUM_ROWS        = 6;
    localparam int MAX_PRESSES     = SEQ_LEN * (SEQ_LEN + 1) / 2;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (SEQ_LEN * SEQ_LEN + TIMEOUT_CYCLES + 20);

    // Segments gfedcba for digits 0 to F, active low
    localparam seg7_t SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    // One scripted game: presses in order, final status and where it ends
    typedef struct packed {
        button_t [MAX_PRESSES-1:0] codes;
        int                        count;
        game_status_t              expected;
        addr_t                     last_round;
        addr_t                     last_pos;
    } script_t;

    logic         clock;
    logic         reset;
    logic         jogar;
    button_t      botoes;
    game_status_t status;
    button_t      leds;
    debug_disp_t  debug;
    game_state_t  db_state;

    script_t script_table [NUM_ROWS];
    int      seed;

    memory_game #(
        .SEQ_LEN        ( SEQ_LEN        ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) i_dut (
        .clock    ( clock    ),
        .reset    ( reset    ),
        .jogar    ( jogar    ),
        .botoes   ( botoes   ),
        .status   ( status   ),
        .leds     ( leds     ),
        .debug    ( debug    ),
        .db_state ( db_state )
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    `include "tb_game_tasks.svh"

    // ----------------------------------------------------------------------
    // Reference sequence and script building
    // ----------------------------------------------------------------------
    // Pattern 1 2 4 8 2 8 1 4, repeated
    function automatic button_t expected_entry(input int index);
        case (index % 8)
            0, 6:    return 4'b0001;
            1, 4:    return 4'b0010;
            2, 7:    return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    // Plays rounds in order until the chosen round and position
    function automatic script_t make_script(input int fail_round, input int fail_pos,
                                            input button_t bad_code, input bit time_out);
        script_t s;
        int      n;
        bit      stopped;
        s       = '0;
        n       = 0;
        stopped = 1'b0;
        for (int r = 0; r < SEQ_LEN; r++) begin
            for (int p = 0; p <= r; p++) begin
                if (!stopped) begin
                    if (r == fail_round && p == fail_pos) begin
                        stopped = 1'b1;
                        // A timeout row simply stops pressing here
                        if (!time_out) begin
                            s.codes[n] = bad_code;
                            n++;
                        end
                    end else begin
                        s.codes[n] = expected_entry(p);
                        n++;
                    end
                end
            end
        end
        s.count           = n;
        s.expected.pronto = 1'b1;
        if (!stopped) begin
            s.expected.acertou = 1'b1;
            s.last_round       = addr_t'(SEQ_LEN - 1);
            s.last_pos         = addr_t'(SEQ_LEN - 1);
        end else begin
            s.expected.errou     = 1'b1;
            s.expected.timed_out = time_out;
            s.last_round         = addr_t'(fail_round);
            s.last_pos           = addr_t'(fail_pos);
        end
        return s;
    endfunction

    // ----------------------------------------------------------------------
    // Game sequencing
    // ----------------------------------------------------------------------
    task automatic start_game();
        jogar = 1'b1;
        @(negedge clock);
        jogar = 1'b0;
        // Old result is gone once the game starts
        check_status('0);
        check_state(start);
    endtask

    task automatic play_script(input script_t s);
        int          hold;
        int          gap;
        int          cycles;
        bit          timeout;
        game_state_t exp_state;
        debug_disp_t exp_debug;
        timeout   = s.expected.timed_out;
        exp_state = s.expected.acertou ? won : lost;
        // Digits once the game is over: last code, position, its entry, state, round
        exp_debug.play    = SEG_TABLE[s.codes[s.count-1]];
        exp_debug.address = SEG_TABLE[s.last_pos];
        exp_debug.memory  = SEG_TABLE[expected_entry(int'(s.last_pos))];
        exp_debug.state   = SEG_TABLE[exp_state];
        exp_debug.limit   = SEG_TABLE[s.last_round];
        start_game();
        for (int i = 0; i < s.count; i++) begin
            if (i == s.count - 1 && !timeout) begin
                press_button(s.codes[i], 1, 0);
            end else begin
                hold = 1 + int'($unsigned($random(seed)) % 3);
                gap  = 2 + int'($unsigned($random(seed)) % 3);
                press_button(s.codes[i], hold, gap);
            end
        end
        if (timeout) begin
            wait_pronto(TIMEOUT_CYCLES + 20, cycles);
        end else begin
            wait_pronto(RESULT_LATENCY + 5, cycles);
            if (cycles != RESULT_LATENCY) begin
                stop_on_error($sformatf("ERR pronto latency expected 0x%h got 0x%h",
                                        RESULT_LATENCY, cycles));
            end
        end
        check_status(s.expected);
        check_state(exp_state);
        check_debug(exp_debug);
        // Result holds while no new game is started
        repeat (2) @(negedge clock);
        check_status(s.expected);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        clock  = 1'b0;
        reset  = 1'b1;
        jogar  = 1'b0;
        botoes = '0;
        seed   = 70299;

        script_table[0] = make_script(-1, 0, 4'b0000, 1'b0);
        script_table[1] = make_script(2, 1, 4'b0100, 1'b0);
        // Two buttons at once on the very first entry
        script_table[2] = make_script(0, 0, 4'b0011, 1'b0);
        script_table[3] = make_script(2, 1, 4'b0000, 1'b1);
        script_table[4] = make_script(3, 3, 4'b0001, 1'b0);
        script_table[5] = make_script(-1, 0, 4'b0000, 1'b0);

        repeat (2) @(negedge clock);
        reset = 1'b0;

        // No game yet, so presses change nothing
        check_status('0);
        check_state(idle);
        repeat (4) begin
            @(negedge clock);
            check_status('0);
        end
        press_button(4'b0100, 1, 3);
        check_status('0);
        check_state(idle);

        for (int row = 0; row < NUM_ROWS; row++) begin
            play_script(script_table[row]);
        end

        $display("Regression passed");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Run timed out after %0d cycles before all games finished", WATCHDOG_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: all.f
+incdir+testbench
rtl/game_pkg.sv
rtl/display_pkg.sv
rtl/play_decoder.sv
rtl/sequence_rom.sv
rtl/game_datapath.sv
rtl/game_control.sv
rtl/status_display.sv
rtl/memory_game.sv
testbench/tb_memory_game.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the memory game testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_memory_game \
    -o tb_memory_game &&
./obj_dir/tb_memory_game | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation PASS" ||
{
    echo "simulation FAIL"
    exit 1
}
